// ==== core_word_pkg.sv ====
`default_nettype none

package core_word_pkg;

    localparam int MAG_W  = 30;
    localparam int ADDR_W = 12;
    localparam int WORD_W = MAG_W + 1;

    // full address space, the largest memory the core can see
    localparam int MEM_MAX = 1 << ADDR_W;

    typedef logic [ADDR_W-1:0] addr_t;

    // sign-magnitude word, sign 1 means minus
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } word_t;

endpackage

`default_nettype wire

// ==== core_order_pkg.sv ====
`default_nettype none

package core_order_pkg;

    localparam int OP_W = 6;

    // order code, magnitude bits 29..24 of an instruction word
    typedef enum logic [OP_W-1:0] {
        ORD_ADD   = 6'o01,
        ORD_SUB   = 6'o02,
        ORD_AND   = 6'o03,
        ORD_LOAD  = 6'o04,
        ORD_STORE = 6'o05,
        ORD_JUMP  = 6'o06,
        ORD_STOP  = 6'o07
    } ord_code_t;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_LOAD,
        ALU_ADD,
        ALU_SUB,
        ALU_AND
    } alu_cmd_t;

    typedef enum logic [2:0] {
        KIND_ARITH,
        KIND_STORE,
        KIND_JUMP,
        KIND_STOP,
        KIND_NOP
    } order_kind_t;

    typedef struct packed {
        order_kind_t          kind;
        alu_cmd_t             alu;
        core_word_pkg::addr_t addr1;
        core_word_pkg::addr_t addr2;
    } order_t;

    typedef enum logic [2:0] {
        SEL_HOLD,
        SEL_STRT,
        SEL_ADDR1,
        SEL_ADDR2
    } sel_src_t;

    typedef enum logic [2:0] {
        PU_IDLE   = 3'd0,
        PU_FETCH  = 3'd1,
        PU_DECODE = 3'd2,
        PU_ISSUE  = 3'd3,
        PU_OPER   = 3'd4,
        PU_PANEL  = 3'd5
    } pu_state_t;

endpackage

`default_nettype wire

// ==== mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_if;

    logic                 read;        // strobe
    logic                 write;       // strobe
    core_word_pkg::addr_t addr;        // select register
    core_word_pkg::word_t wdata;       // register C
    core_word_pkg::word_t rdata;
    logic                 read_reply;  // one cycle after read

    modport seq (
        output read,
        output write,
        input  read_reply
    );

    modport addr_src (
        output addr
    );

    modport data_src (
        output wdata,
        input  rdata
    );

    modport data_rx (
        input  rdata
    );

    modport mem (
        input  read,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output read_reply
    );

endinterface

`default_nettype wire

// ==== pulse_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module pulse_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_pulse,
    input  logic                          clear_pu,
    input  logic                          run_auto,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  core_order_pkg::order_t        order,
    mem_if.seq                            seq,
    output logic                          do_code_to_op,
    output core_order_pkg::alu_cmd_t      alu_cmd,
    output core_order_pkg::sel_src_t      sel_src,
    output logic                          do_inc_strt,
    output logic                          do_jump,
    output core_order_pkg::pu_state_t     pu_state
);

    core_order_pkg::pu_state_t state_q;
    core_order_pkg::pu_state_t state_d;
    core_order_pkg::pu_state_t after_order;
    logic                      read_d;
    logic                      write_d;
    logic                      fetch_reply;

    // STOP always ends the run
    assign after_order = (run_auto && order.kind != core_order_pkg::KIND_STOP) ?
                         core_order_pkg::PU_FETCH : core_order_pkg::PU_IDLE;

    always_comb begin
        state_d = state_q;
        read_d  = 1'b0;
        write_d = 1'b0;
        case (state_q)
            core_order_pkg::PU_IDLE: begin
                if (start_pulse) begin
                    state_d = core_order_pkg::PU_FETCH;
                end else if (mem_read) begin
                    state_d = core_order_pkg::PU_PANEL;
                    read_d  = 1'b1;
                end else if (mem_write) begin
                    write_d = 1'b1;  // no state change for a panel write
                end
            end
            core_order_pkg::PU_FETCH: begin
                state_d = core_order_pkg::PU_DECODE;
                read_d  = 1'b1;
            end
            core_order_pkg::PU_DECODE: begin
                if (seq.read_reply) state_d = core_order_pkg::PU_ISSUE;
            end
            core_order_pkg::PU_ISSUE: begin
                state_d = after_order;
                if (order.kind == core_order_pkg::KIND_ARITH) begin
                    state_d = core_order_pkg::PU_OPER;
                    read_d  = 1'b1;
                end else if (order.kind == core_order_pkg::KIND_STORE) begin
                    write_d = 1'b1;
                end
            end
            core_order_pkg::PU_OPER: begin
                if (seq.read_reply) state_d = after_order;
            end
            core_order_pkg::PU_PANEL: begin
                if (seq.read_reply) state_d = core_order_pkg::PU_IDLE;
            end
            default: state_d = core_order_pkg::PU_IDLE;
        endcase
        if (clear_pu) begin
            state_d = core_order_pkg::PU_IDLE;
            read_d  = 1'b0;
            write_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= core_order_pkg::PU_IDLE;
            seq.read  <= 1'b0;
            seq.write <= 1'b0;
        end else begin
            state_q   <= state_d;
            seq.read  <= read_d;
            seq.write <= write_d;
        end
    end

    // select register loads at the end of this cycle
    always_comb begin
        sel_src = core_order_pkg::SEL_HOLD;
        if (state_q == core_order_pkg::PU_FETCH) begin
            sel_src = core_order_pkg::SEL_STRT;
        end else if (state_q == core_order_pkg::PU_ISSUE) begin
            if (order.kind == core_order_pkg::KIND_ARITH)
                sel_src = core_order_pkg::SEL_ADDR1;
            else if (order.kind == core_order_pkg::KIND_STORE)
                sel_src = core_order_pkg::SEL_ADDR2;
        end
    end

    always_comb begin
        alu_cmd = core_order_pkg::ALU_NONE;
        if (seq.read_reply) begin
            if (state_q == core_order_pkg::PU_OPER)
                alu_cmd = order.alu;
            else if (state_q == core_order_pkg::PU_PANEL)
                alu_cmd = core_order_pkg::ALU_LOAD;  // panel read lands in C
        end
    end

    assign fetch_reply   = (state_q == core_order_pkg::PU_DECODE) && seq.read_reply;
    assign do_code_to_op = fetch_reply;
    assign do_inc_strt   = fetch_reply;
    assign do_jump       = (state_q == core_order_pkg::PU_ISSUE) &&
                           (order.kind == core_order_pkg::KIND_JUMP);
    assign pu_state      = state_q;

endmodule

`default_nettype wire

// ==== operator.sv ====
`timescale 1ns/10ps
`default_nettype none

module operator (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            do_code_to_op,
    mem_if.data_rx                          bus,
    output core_order_pkg::order_t          order,
    output logic [core_order_pkg::OP_W-1:0] op_code
);

    logic [core_word_pkg::MAG_W-1:0] ord_q;  // sign of the fetched word is dropped
    core_order_pkg::ord_code_t       code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ord_q <= '0;
        else if (do_code_to_op)
            ord_q <= bus.rdata.mag;
    end

    assign code = core_order_pkg::ord_code_t'(
        ord_q[core_word_pkg::MAG_W-1 -: core_order_pkg::OP_W]);

    always_comb begin
        order.addr1 = ord_q[2*core_word_pkg::ADDR_W-1 -: core_word_pkg::ADDR_W];
        order.addr2 = ord_q[core_word_pkg::ADDR_W-1:0];
        order.kind  = core_order_pkg::KIND_ARITH;
        order.alu   = core_order_pkg::ALU_NONE;
        case (code)
            core_order_pkg::ORD_ADD:   order.alu  = core_order_pkg::ALU_ADD;
            core_order_pkg::ORD_SUB:   order.alu  = core_order_pkg::ALU_SUB;
            core_order_pkg::ORD_AND:   order.alu  = core_order_pkg::ALU_AND;
            core_order_pkg::ORD_LOAD:  order.alu  = core_order_pkg::ALU_LOAD;
            core_order_pkg::ORD_STORE: order.kind = core_order_pkg::KIND_STORE;
            core_order_pkg::ORD_JUMP:  order.kind = core_order_pkg::KIND_JUMP;
            core_order_pkg::ORD_STOP:  order.kind = core_order_pkg::KIND_STOP;
            default:                   order.kind = core_order_pkg::KIND_NOP;
        endcase
    end

    assign op_code = code;

endmodule

`default_nettype wire

// ==== arith_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module arith_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_order_pkg::alu_cmd_t alu_cmd,
    input  logic                     do_arr_c,
    input  core_word_pkg::word_t     arr_reg_c_value,
    mem_if.data_src                  bus,
    output core_word_pkg::word_t     reg_c
);

    core_word_pkg::word_t            c_q;
    core_word_pkg::word_t            res;
    logic                            m_sign;
    logic [core_word_pkg::MAG_W:0]   diff;   // top bit is the borrow
    logic [core_word_pkg::MAG_W-1:0] res_mag;
    logic                            res_sign;

    assign m_sign = bus.rdata.sign ^ (alu_cmd == core_order_pkg::ALU_SUB);
    assign diff   = {1'b0, c_q.mag} - {1'b0, bus.rdata.mag};

    always_comb begin
        res_sign = c_q.sign;
        res_mag  = c_q.mag;
        case (alu_cmd)
            core_order_pkg::ALU_LOAD: begin
                res_sign = bus.rdata.sign;
                res_mag  = bus.rdata.mag;
            end
            core_order_pkg::ALU_ADD,
            core_order_pkg::ALU_SUB: begin
                if (c_q.sign == m_sign) begin
                    res_mag = c_q.mag + bus.rdata.mag;  // carry out lost
                end else if (diff[core_word_pkg::MAG_W]) begin
                    res_mag  = bus.rdata.mag - c_q.mag;
                    res_sign = m_sign;
                end else begin
                    res_mag = diff[core_word_pkg::MAG_W-1:0];
                end
            end
            core_order_pkg::ALU_AND: begin
                res_sign = c_q.sign & bus.rdata.sign;
                res_mag  = c_q.mag & bus.rdata.mag;
            end
            default: ;
        endcase
    end

    // no minus zero
    assign res.sign = res_sign && (res_mag != '0);
    assign res.mag  = res_mag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            c_q <= '0;
        else if (do_arr_c)
            c_q <= arr_reg_c_value;
        else if (alu_cmd != core_order_pkg::ALU_NONE)
            c_q <= res;
    end

    assign reg_c     = c_q;
    assign bus.wdata = c_q;  // store always writes C

endmodule

`default_nettype wire

// ==== addr_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     do_arr_strt,
    input  core_word_pkg::addr_t     arr_strt_value,
    input  logic                     do_arr_sel,
    input  core_word_pkg::addr_t     arr_sel_value,
    input  core_order_pkg::sel_src_t sel_src,
    input  logic                     do_inc_strt,
    input  logic                     do_jump,
    input  core_order_pkg::order_t   order,
    mem_if.addr_src                  bus,
    output core_word_pkg::addr_t     strt_value,
    output core_word_pkg::addr_t     sel_value
);

    core_word_pkg::addr_t strt_q;
    core_word_pkg::addr_t sel_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            strt_q <= '0;
        else if (do_arr_strt)
            strt_q <= arr_strt_value;
        else if (do_jump)
            strt_q <= order.addr2;
        else if (do_inc_strt)
            strt_q <= strt_q + 1'b1;  // wraps at 4096
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (do_arr_sel) begin
            sel_q <= arr_sel_value;
        end else begin
            case (sel_src)
                core_order_pkg::SEL_STRT:  sel_q <= strt_q;
                core_order_pkg::SEL_ADDR1: sel_q <= order.addr1;
                core_order_pkg::SEL_ADDR2: sel_q <= order.addr2;
                default: ;
            endcase
        end
    end

    assign bus.addr   = sel_q;
    assign strt_value = strt_q;
    assign sel_value  = sel_q;

endmodule

`default_nettype wire

// ==== memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory #(
    parameter int MEM_DEPTH = 4096
) (
    input  logic clk,
    input  logic rst_n,
    mem_if.mem   bus
);

    core_word_pkg::word_t ram [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (bus.write)
            ram[bus.addr] <= bus.wdata;
    end

    // registered read data, held until the next read
    always_ff @(posedge clk) begin
        if (bus.read)
            bus.rdata <= ram[bus.addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bus.read_reply <= 1'b0;
        else
            bus.read_reply <= bus.read;
    end

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_top #(
    parameter int MEM_DEPTH = core_word_pkg::MEM_MAX
) (
    input  logic clk,
    input  logic rst_n,

    input  logic pnl_start_pulse,                        // pulse
    input  logic pnl_clear_pu,                           // pulse
    input  logic pnl_automatic,                          // level

    input  logic pnl_mem_read,                           // pulse
    input  logic pnl_mem_write,                          // pulse

    input  logic pnl_do_arr_c,                           // pulse
    input  logic [core_word_pkg::WORD_W-1:0] pnl_arr_reg_c_value,

    input  logic pnl_do_arr_strt,                        // pulse
    input  core_word_pkg::addr_t pnl_arr_strt_value,

    input  logic pnl_do_arr_sel,                         // pulse
    input  core_word_pkg::addr_t pnl_arr_sel_value,

    output logic [core_order_pkg::OP_W-1:0] pnl_op_code,
    output core_word_pkg::addr_t pnl_strt_value,
    output core_word_pkg::addr_t pnl_sel_value,
    output logic [core_word_pkg::WORD_W-1:0] pnl_reg_c_value,
    output logic [2:0] pnl_pu_state
);

    core_order_pkg::order_t   order_from_op;
    core_order_pkg::alu_cmd_t alu_cmd_from_pu;
    core_order_pkg::sel_src_t sel_src_from_pu;
    logic                     do_code_to_op_from_pu;
    logic                     do_inc_strt_from_pu;
    logic                     do_jump_from_pu;

    mem_if mem_bus ();

    pulse_unit u_pulse_unit (
        .clk           ( clk                   ),
        .rst_n         ( rst_n                 ),
        .start_pulse   ( pnl_start_pulse       ),
        .clear_pu      ( pnl_clear_pu          ),
        .run_auto      ( pnl_automatic         ),
        .mem_read      ( pnl_mem_read          ),
        .mem_write     ( pnl_mem_write         ),
        .order         ( order_from_op         ),
        .seq           ( mem_bus               ),
        .do_code_to_op ( do_code_to_op_from_pu ),
        .alu_cmd       ( alu_cmd_from_pu       ),
        .sel_src       ( sel_src_from_pu       ),
        .do_inc_strt   ( do_inc_strt_from_pu   ),
        .do_jump       ( do_jump_from_pu       ),
        .pu_state      ( pnl_pu_state          )
    );

    operator u_operator (
        .clk           ( clk                   ),
        .rst_n         ( rst_n                 ),
        .do_code_to_op ( do_code_to_op_from_pu ),
        .bus           ( mem_bus               ),
        .order         ( order_from_op         ),
        .op_code       ( pnl_op_code           )
    );

    arith_unit u_arith_unit (
        .clk             ( clk                 ),
        .rst_n           ( rst_n               ),
        .alu_cmd         ( alu_cmd_from_pu     ),
        .do_arr_c        ( pnl_do_arr_c        ),
        .arr_reg_c_value ( pnl_arr_reg_c_value ),
        .bus             ( mem_bus             ),
        .reg_c           ( pnl_reg_c_value     )
    );

    addr_regs u_addr_regs (
        .clk            ( clk                 ),
        .rst_n          ( rst_n               ),
        .do_arr_strt    ( pnl_do_arr_strt     ),
        .arr_strt_value ( pnl_arr_strt_value  ),
        .do_arr_sel     ( pnl_do_arr_sel      ),
        .arr_sel_value  ( pnl_arr_sel_value   ),
        .sel_src        ( sel_src_from_pu     ),
        .do_inc_strt    ( do_inc_strt_from_pu ),
        .do_jump        ( do_jump_from_pu     ),
        .order          ( order_from_op       ),
        .bus            ( mem_bus             ),
        .strt_value     ( pnl_strt_value      ),
        .sel_value      ( pnl_sel_value       )
    );

    memory #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) u_memory (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .bus   ( mem_bus )
    );

endmodule

`default_nettype wire

// ==== tb_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_core_top;

    logic        clk;
    logic        rst_n;
    logic        pnl_start_pulse;
    logic        pnl_clear_pu;
    logic        pnl_automatic;
    logic        pnl_mem_read;
    logic        pnl_mem_write;
    logic        pnl_do_arr_c;
    logic [30:0] pnl_arr_reg_c_value;
    logic        pnl_do_arr_strt;
    logic [11:0] pnl_arr_strt_value;
    logic        pnl_do_arr_sel;
    logic [11:0] pnl_arr_sel_value;
    logic [5:0]  pnl_op_code;
    logic [11:0] pnl_strt_value;
    logic [11:0] pnl_sel_value;
    logic [30:0] pnl_reg_c_value;
    logic [2:0]  pnl_pu_state;

    logic [31:0] lfsr = 32'hd08;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    core_top #(.MEM_DEPTH(4096)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [30:0] make_order(input logic [5:0] code,
                                               input logic [11:0] a1, input logic [11:0] a2);
        return {1'b0, code, a1, a2};
    endfunction

    // reference arithmetic on signed integers
    function automatic logic [30:0] model_alu(input logic [5:0] code,
                                              input logic [30:0] c, input logic [30:0] m);
        longint      vc;
        longint      vm;
        longint      sum;
        longint      abs_sum;
        logic [30:0] r;
        vc = c[30] ? -longint'(c[29:0]) : longint'(c[29:0]);
        vm = m[30] ? -longint'(m[29:0]) : longint'(m[29:0]);
        r = c;
        if (code == core_order_pkg::ORD_LOAD) begin
            r = m;
        end else if (code == core_order_pkg::ORD_ADD || code == core_order_pkg::ORD_SUB) begin
            if (code == core_order_pkg::ORD_SUB)
                vm = -vm;
            sum = vc + vm;
            abs_sum = (sum < 0) ? -sum : sum;
            r = {sum < 0, abs_sum[29:0]};  // mod 2^30
        end else if (code == core_order_pkg::ORD_AND) begin
            r = {c[30] & m[30], c[29:0] & m[29:0]};
        end
        if (r[29:0] == 30'd0)
            r[30] = 1'b0;
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (pnl_pu_state != core_order_pkg::PU_IDLE && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (pnl_pu_state != core_order_pkg::PU_IDLE) begin
            timeouts++;
            $display("Timeout: pulse unit never returned to idle after %s", what);
        end
    endtask

    task automatic arrange_c(input logic [30:0] v);
        @(posedge clk);
        pnl_arr_reg_c_value <= v;
        pnl_do_arr_c        <= 1'b1;
        @(posedge clk);
        pnl_do_arr_c        <= 1'b0;
    endtask

    task automatic arrange_strt(input logic [11:0] a);
        @(posedge clk);
        pnl_arr_strt_value <= a;
        pnl_do_arr_strt    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_strt    <= 1'b0;
    endtask

    task automatic arrange_sel(input logic [11:0] a);
        @(posedge clk);
        pnl_arr_sel_value <= a;
        pnl_do_arr_sel    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_sel    <= 1'b0;
    endtask

    task automatic panel_write(input logic [11:0] a, input logic [30:0] w);
        arrange_sel(a);
        arrange_c(w);
        @(posedge clk);
        pnl_mem_write <= 1'b1;
        @(posedge clk);
        pnl_mem_write <= 1'b0;
        repeat (2) @(posedge clk);  // write lands one cycle later
    endtask

    task automatic panel_read(input logic [11:0] a);
        arrange_sel(a);
        @(posedge clk);
        pnl_mem_read <= 1'b1;
        @(posedge clk);
        pnl_mem_read <= 1'b0;
        wait_idle("a panel read");
    endtask

    task automatic pulse_start(input logic run_auto);
        @(posedge clk);
        pnl_automatic   <= run_auto;
        pnl_start_pulse <= 1'b1;
        @(posedge clk);
        pnl_start_pulse <= 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value(pnl_reg_c_value, 0, "C after reset");
        check_value(pnl_strt_value, 0, "start register after reset");
        check_value(pnl_sel_value, 0, "select register after reset");
        check_value(pnl_op_code, 0, "order code after reset");
        check_value(pnl_pu_state, core_order_pkg::PU_IDLE, "pulse unit state after reset");
    endtask

    task automatic test_arrange();
        logic [31:0] r;
        random_bits(31, r);
        arrange_c(r[30:0]);
        @(negedge clk);
        check_value(pnl_reg_c_value, r[30:0], "arranged C");
        random_bits(12, r);
        arrange_strt(r[11:0]);
        @(negedge clk);
        check_value(pnl_strt_value, r[11:0], "arranged start register");
        random_bits(12, r);
        arrange_sel(r[11:0]);
        @(negedge clk);
        check_value(pnl_sel_value, r[11:0], "arranged select register");
    endtask

    task automatic test_panel_memory();
        logic [11:0] addrs [5];
        logic [30:0] words [5];
        logic [31:0] r;
        addrs = '{12'h000, 12'h7ff, 12'h800, 12'hfff, 12'h123};
        for (int i = 0; i < 5; i++) begin
            random_bits(31, r);
            words[i] = r[30:0];
            panel_write(addrs[i], words[i]);
        end
        for (int i = 0; i < 5; i++) begin
            panel_read(addrs[i]);
            check_value(pnl_reg_c_value, words[i], $sformatf("panel read of %h", addrs[i]));
        end
    endtask

    // one order at 200+idx with its operand at 300+idx
    task automatic run_single(input logic [5:0] code, input logic [30:0] c,
                              input logic [30:0] m, input int idx);
        logic [11:0] pc;
        pc = 12'h200 + idx;
        panel_write(12'h300 + idx, m);
        panel_write(pc, make_order(code, 12'h300 + idx, 12'h000));
        arrange_c(c);
        arrange_strt(pc);
        pulse_start(1'b0);
        wait_idle("a single order");
        check_value(pnl_reg_c_value, model_alu(code, c, m), $sformatf("C after order %o", code));
        check_value(pnl_strt_value, pc + 1, "start register after a single order");
    endtask

    task automatic test_single_orders();
        logic [31:0] c;
        logic [31:0] m;
        logic [31:0] r;
        random_bits(31, c);
        random_bits(31, m);
        run_single(core_order_pkg::ORD_LOAD, c[30:0], m[30:0], 0);
        random_bits(31, c);
        random_bits(31, m);
        run_single(core_order_pkg::ORD_ADD, c[30:0], m[30:0], 1);
        random_bits(31, c);
        random_bits(31, m);
        run_single(core_order_pkg::ORD_SUB, c[30:0], m[30:0], 2);
        random_bits(31, c);
        random_bits(31, m);
        run_single(core_order_pkg::ORD_AND, c[30:0], m[30:0], 3);
        random_bits(30, c);
        run_single(core_order_pkg::ORD_SUB, {1'b1, c[29:0]}, {1'b1, c[29:0]}, 4);  // zero
        run_single(core_order_pkg::ORD_ADD, {1'b1, c[29:0]}, {1'b0, c[29:0]}, 5);
        random_bits(31, r);
        panel_write(12'h210, make_order(core_order_pkg::ORD_STORE, 12'h000, 12'h400));
        arrange_c(r[30:0]);
        arrange_strt(12'h210);
        pulse_start(1'b0);
        wait_idle("a store order");
        check_value(pnl_strt_value, 12'h211, "start register after store");
        arrange_c(~r[30:0]);
        panel_read(12'h400);
        check_value(pnl_reg_c_value, r[30:0], "word stored by STORE");
    endtask

    task automatic test_auto_program();
        logic [30:0] d [4];
        logic [31:0] r;
        logic [30:0] exp;
        for (int i = 0; i < 4; i++) begin
            random_bits(31, r);
            d[i] = r[30:0];
            panel_write(12'h600 + i, d[i]);
        end
        panel_write(12'h500, make_order(core_order_pkg::ORD_LOAD, 12'h600, 12'h000));
        panel_write(12'h501, make_order(core_order_pkg::ORD_ADD, 12'h601, 12'h000));
        panel_write(12'h502, make_order(core_order_pkg::ORD_JUMP, 12'h000, 12'h504));
        panel_write(12'h503, make_order(core_order_pkg::ORD_SUB, 12'h602, 12'h000));  // skipped
        panel_write(12'h504, make_order(core_order_pkg::ORD_SUB, 12'h603, 12'h000));
        panel_write(12'h505, make_order(core_order_pkg::ORD_STOP, 12'h000, 12'h000));
        exp = model_alu(core_order_pkg::ORD_ADD, d[0], d[1]);
        exp = model_alu(core_order_pkg::ORD_SUB, exp, d[3]);
        arrange_strt(12'h500);
        pulse_start(1'b1);
        wait_idle("an automatic run");
        check_value(pnl_reg_c_value, exp, "C after automatic run");
        check_value(pnl_strt_value, 12'h506, "start register after STOP");
        check_value(pnl_op_code, core_order_pkg::ORD_STOP, "order code after STOP");
    endtask

    task automatic test_clear_loop();
        panel_write(12'h700, make_order(core_order_pkg::ORD_JUMP, 12'h000, 12'h700));
        arrange_strt(12'h700);
        pulse_start(1'b1);
        repeat (20) @(negedge clk);
        check_value(pnl_pu_state != core_order_pkg::PU_IDLE, 1, "jump loop still running");
        @(posedge clk);
        pnl_clear_pu <= 1'b1;
        @(posedge clk);
        pnl_clear_pu <= 1'b0;
        @(negedge clk);  // automatic still high, only the clear can stop the loop
        check_value(pnl_pu_state, core_order_pkg::PU_IDLE, "state one cycle after clear");
        repeat (4) @(negedge clk);
        check_value(pnl_pu_state, core_order_pkg::PU_IDLE, "state stays idle after clear");
        @(posedge clk);
        pnl_automatic <= 1'b0;
    endtask

    initial begin
        rst_n               = 1'b0;
        pnl_start_pulse     = 1'b0;
        pnl_clear_pu        = 1'b0;
        pnl_automatic       = 1'b0;
        pnl_mem_read        = 1'b0;
        pnl_mem_write       = 1'b0;
        pnl_do_arr_c        = 1'b0;
        pnl_arr_reg_c_value = '0;
        pnl_do_arr_strt     = 1'b0;
        pnl_arr_strt_value  = '0;
        pnl_do_arr_sel      = 1'b0;
        pnl_arr_sel_value   = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_arrange();
        test_panel_memory();
        test_single_orders();
        test_auto_program();
        test_clear_loop();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
core_word_pkg.sv
core_order_pkg.sv
mem_if.sv
pulse_unit.sv
operator.sv
arith_unit.sv
addr_regs.sv
memory.sv
core_top.sv
tb_core_top.sv
